//--- riscv_icache.f
common/icache_pkg.sv
common/icache_fill_if.sv
icache/icache_ctrl.sv
icache/riscv_icache_inst.sv
icache/icache_tag.sv
icache/icache_align.sv
icache/riscv_icache.sv
verification/tb_clock_gen.sv
verification/tb_riscv_icache.sv

//--- Makefile
TOP  := tb_riscv_icache
SRCS := $(shell cat riscv_icache.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): riscv_icache.f $(SRCS)
	verilator --binary --timing -j 0 --top-module $(TOP) -f riscv_icache.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- verification/tb_riscv_icache.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench of the instruction cache with a hashed memory model
// memory answers each block request after 1 to 6 cycles
// fetch addresses are halfword aligned and stay below the top of memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_riscv_icache import icache_pkg::*; ();

  localparam logic [31:0] SEED = 32'h0bc300d3;
  localparam int TIMEOUT = 200;
  localparam addr_t RAND_BASE = 32'h0000_5000;

  logic clk;
  logic rst_n;
  logic fetch_req;
  addr_t fetch_addr;
  logic fence_i;
  logic fetch_busy;
  logic instr_valid;
  instr_t instr;
  logic mem_req;
  addr_t mem_addr;
  logic mem_valid = 1'b0;
  block_t mem_data = '0;

  logic [31:0] stim_rng = SEED;
  logic [31:0] mem_rng = SEED;
  int mem_delay;
  addr_t mem_base;
  // expected values of the fetch in flight
  addr_t exp_addr;
  int exp_reqs;
  int exp_latency;
  int start_reqs;
  int issue_cycle;
  // block addresses expected on mem_addr, in request order
  addr_t exp_miss[$];
  int issued = 0;
  int results = 0;
  int req_seen = 0;
  int cycle = 0;
  int checks = 0;
  int errors = 0;
  logic timed_out = 1'b0;
  // blocks the cache should hold
  logic [ICACHE_DEPTH-1:0] model_valid = '0;
  tag_t model_tag [ICACHE_DEPTH];

  tb_clock_gen clock_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  riscv_icache riscv_icache_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fence_i     (fence_i),
    .fetch_busy  (fetch_busy),
    .instr_valid (instr_valid),
    .instr       (instr),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_valid   (mem_valid),
    .mem_data    (mem_data)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // every memory byte is a hash of its own address
  function automatic logic [7:0] mem_byte(input addr_t a);
    logic [31:0] h;
    h = a * 32'h9e3779b1;
    h = h ^ (h >> 15);
    return h[7:0] ^ h[23:16];
  endfunction

  function automatic block_t block_at(input addr_t base);
    block_t data;
    for (int b = 0; b < ICACHE_BYTES; b++) begin
      data[8*b +: 8] = mem_byte(base + addr_t'(b));
    end
    return data;
  endfunction

  // little endian word starting at the fetch address
  function automatic instr_t ref_instr(input addr_t a);
    return {mem_byte(a + 32'd3), mem_byte(a + 32'd2), mem_byte(a + 32'd1), mem_byte(a)};
  endfunction

  function automatic addr_t random_addr(input logic [31:0] r);
    int tsel;
    int isel;
    int hsel;
    // three tags over four indices so that blocks evict each other
    tsel = int'(r[17:16]) % 3;
    isel = int'(r[13:12]);
    hsel = int'(r[3:1]);
    return RAND_BASE + addr_t'(tsel * 'h400 + isel * 'h10 + hsel * 2);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic touch_block(input addr_t blk, inout int reqs);
    index_t idx;
    tag_t tg;
    idx = blk[ICACHE_TAG_LSB-1:ICACHE_INDEX_LSB];
    tg = blk[ICACHE_ADDR_W-1:ICACHE_TAG_LSB];
    if (!(model_valid[idx] && model_tag[idx] == tg)) begin
      reqs++;
      exp_miss.push_back(blk);
      model_valid[idx] = 1'b1;
      model_tag[idx] = tg;
    end
  endtask

  // counts the misses of one fetch in the addressed block and then the following one
  task automatic model_fetch(input addr_t addr, output int reqs);
    addr_t blk;
    reqs = 0;
    blk = {addr[ICACHE_ADDR_W-1:ICACHE_OFFSET_W], {ICACHE_OFFSET_W{1'b0}}};
    touch_block(blk, reqs);
    if (addr[ICACHE_OFFSET_W-1:0] == ICACHE_LAST_HALF) begin
      touch_block(blk + addr_t'(ICACHE_BYTES), reqs);
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (fetch_busy && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (fetch_busy) begin
      timed_out = 1'b1;
      $display("Error at %0t ns: fetch_busy stayed high for %0d cycles", $time, TIMEOUT);
    end
  endtask

  // a negative reqs_exp takes the count from the block model
  task automatic do_fetch(input addr_t addr, input int reqs_exp, input int lat_exp);
    int model_reqs;
    int cycles;
    logic seen;
    wait_idle();
    if (!timed_out) begin
      exp_miss.delete();
      model_fetch(addr, model_reqs);
      exp_addr = addr;
      exp_reqs = (reqs_exp < 0) ? model_reqs : reqs_exp;
      exp_latency = lat_exp;
      start_reqs = req_seen;
      issue_cycle = cycle;
      issued++;
      fetch_req = 1'b1;
      fetch_addr = addr;
      @(posedge clk);
      #1;
      fetch_req = 1'b0;
      check("fetch_busy", 32'(fetch_busy), 32'd1);
      cycles = 0;
      seen = 1'b0;
      while (!seen && cycles < TIMEOUT) begin
        @(posedge clk);
        cycles++;
        seen = instr_valid;
      end
      #1;
      if (!seen) begin
        timed_out = 1'b1;
        $display("Error at %0t ns: no instr_valid within %0d cycles of the fetch at %h",
                 $time, TIMEOUT, addr);
      end
    end
  endtask

  task automatic pulse_fence();
    wait_idle();
    if (!timed_out) begin
      fence_i = 1'b1;
      @(posedge clk);
      #1;
      fence_i = 1'b0;
      model_valid = '0;
    end
  endtask

  // memory model
  always begin
    @(posedge clk);
    if (rst_n && mem_req) begin
      mem_rng = xorshift32(mem_rng);
      mem_delay = 1 + int'(mem_rng % 32'd6);
      mem_base = mem_addr;
      repeat (mem_delay - 1) @(posedge clk);
      #1;
      mem_valid = 1'b1;
      mem_data = block_at(mem_base);
      @(posedge clk);
      #1;
      mem_valid = 1'b0;
    end
  end

  // compare process sampling at the rising edge
  always @(posedge clk) begin
    cycle++;
    if (rst_n && mem_req) begin
      req_seen++;
      if (exp_miss.size() > 0) begin
        check("mem_addr", mem_addr, exp_miss.pop_front());
      end else begin
        errors++;
        $display("Error at %0t ns: mem_req for %h while no block should miss",
                 $time, mem_addr);
      end
    end
    if (rst_n && issued == 0) begin
      check("fetch_busy", 32'(fetch_busy), 32'd0);
      check("instr_valid", 32'(instr_valid), 32'd0);
      check("mem_req", 32'(mem_req), 32'd0);
    end
    if (rst_n && instr_valid) begin
      if (results < issued) begin
        results++;
        check("instr", instr, ref_instr(exp_addr));
        check("mem_req count", 32'(req_seen - start_reqs), 32'(exp_reqs));
        if (exp_latency >= 0) begin
          check("hit latency", 32'(cycle - issue_cycle - 1), 32'(exp_latency));
        end
      end else begin
        errors++;
        $display("Error at %0t ns: instr_valid without a fetch in flight", $time);
      end
    end
  end

  initial begin
    int cycles;
    fetch_req = 1'b0;
    fetch_addr = '0;
    fence_i = 1'b0;
    cycles = 0;
    while (!rst_n && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    #1;
    if (!rst_n) begin
      timed_out = 1'b1;
      $display("Error at %0t ns: reset was never released", $time);
    end
    // idle outputs after reset are checked while nothing was issued
    repeat (10) @(posedge clk);
    #1;
    do_fetch(32'h0000_1040, 1, -1);
    do_fetch(32'h0000_1044, 0, 2);
    do_fetch(32'h0000_104a, 0, 2);
    // offset 14 with both blocks cold and then with both present
    do_fetch(32'h0000_20ae, 2, -1);
    do_fetch(32'h0000_20ae, 0, 2);
    // only the following block cold
    do_fetch(32'h0000_30c0, 1, -1);
    do_fetch(32'h0000_30ce, 1, -1);
    // the following block of the last index wraps to index 0 with the next tag
    do_fetch(32'h0000_43fe, 2, -1);
    do_fetch(32'h0000_43fe, 0, 2);
    pulse_fence();
    do_fetch(32'h0000_1044, 1, -1);
    for (int i = 0; i < 200; i++) begin
      stim_rng = xorshift32(stim_rng);
      do_fetch(random_addr(stim_rng), -1, -1);
    end
    @(posedge clk);
    #1;
    $display("checks %0d, errors %0d, timeouts %0d, fetches %0d, memory requests %0d",
             checks, errors, timed_out, issued, req_seen);
    if (errors == 0 && !timed_out && results == issued) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verification/tb_clock_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock of 8 ns and active low reset
// rst_n is released 1 ns after the 8th rising edge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 4;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

//--- icache/riscv_icache.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// direct-mapped instruction cache, one fetch in flight at a time
// hit latency is 2 cycles from the fetch_req cycle to instr_valid
// memory returns one whole block per mem_req, with no timeout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module riscv_icache import icache_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   fetch_req,
  input  addr_t  fetch_addr,
  input  logic   fence_i,
  output logic   fetch_busy,
  output logic   instr_valid,
  output instr_t instr,
  output logic   mem_req,
  output addr_t  mem_addr,
  input  logic   mem_valid,
  input  block_t mem_data
);

  logic                       hit;
  logic                       next_hit;
  logic                       flush;
  index_t                     index;
  index_t                     next_index;
  tag_t                       tag;
  tag_t                       next_tag;
  logic [ICACHE_OFFSET_W-1:0] offset;
  block_t                     block;
  block_t                     next_block;

  icache_fill_if fill_bus ();

  icache_ctrl ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fence_i     (fence_i),
    .fetch_busy  (fetch_busy),
    .instr_valid (instr_valid),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_valid   (mem_valid),
    .mem_data    (mem_data),
    .hit         (hit),
    .next_hit    (next_hit),
    .index       (index),
    .next_index  (next_index),
    .tag         (tag),
    .next_tag    (next_tag),
    .offset      (offset),
    .flush       (flush),
    .fill        (fill_bus.mp_ctrl)
  );

  riscv_icache_inst data_i (
    .clk           (clk),
    .fill          (fill_bus.mp_array),
    .index         (index),
    .next_index    (next_index),
    .data_out      (block),
    .data_out_next (next_block)
  );

  icache_tag tag_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .fill       (fill_bus.mp_array),
    .index      (index),
    .next_index (next_index),
    .tag        (tag),
    .next_tag   (next_tag),
    .hit        (hit),
    .next_hit   (next_hit)
  );

  icache_align align_i (
    .block      (block),
    .next_block (next_block),
    .offset     (offset),
    .instr      (instr)
  );

endmodule

//--- icache/icache_align.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// picks the 32-bit instruction at a halfword offset, little endian
// offset bit 0 is ignored since fetches are halfword aligned
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module icache_align import icache_pkg::*; (
  input  block_t                     block,
  input  block_t                     next_block,
  input  logic [ICACHE_OFFSET_W-1:0] offset,
  output instr_t                     instr
);

  logic [ICACHE_BLOCK_W+ICACHE_INSTR_W-1:0] span;
  logic [ICACHE_OFFSET_W+2:0]               bit_pos;

  // low bytes of the following block sit just above the addressed block
  assign span = {next_block[ICACHE_INSTR_W-1:0], block};

  // halfword number times 16 bits
  assign bit_pos = {offset[ICACHE_OFFSET_W-1:1], 4'b0000};

  assign instr = span[bit_pos +: ICACHE_INSTR_W];

endmodule

//--- icache/icache_tag.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag store with one valid bit per block
// tags are written and read at the falling edge, valid bits at the rising
// hit and next_hit compare against the requested tags combinationally
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module icache_tag import icache_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush,
  icache_fill_if.mp_array  fill,
  input  index_t           index,
  input  index_t           next_index,
  input  tag_t             tag,
  input  tag_t             next_tag,
  output logic             hit,
  output logic             next_hit
);

  tag_t              tag_ram [ICACHE_DEPTH];
  logic [ICACHE_DEPTH-1:0] valid;
  index_t            wr_index;
  tag_t              rd_tag;
  tag_t              rd_tag_next;
  logic              rd_valid;
  logic              rd_valid_next;

  assign wr_index = fill.index_sel ? next_index : index;

  always_ff @(negedge clk) begin
    if (fill.wren) begin
      tag_ram[wr_index] <= fill.tag;
    end
  end

  // set at the end of the write cycle, seen by the next lookup read
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid <= '0;
    end else if (fill.wren) begin
      valid[wr_index] <= 1'b1;
    end
  end

  always_ff @(negedge clk) begin
    rd_tag        <= tag_ram[index];
    rd_tag_next   <= tag_ram[next_index];
    rd_valid      <= valid[index];
    rd_valid_next <= valid[next_index];
  end

  assign hit      = rd_valid && (rd_tag == tag);
  assign next_hit = rd_valid_next && (rd_tag_next == next_tag);

endmodule

//--- icache/riscv_icache_inst.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// block RAM of the cache, one byte lane per array
// reads of both blocks and the refill write happen at the falling edge
// contents are undefined until written, the tag store guards them
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module riscv_icache_inst import icache_pkg::*; (
  input  logic             clk,
  icache_fill_if.mp_array  fill,
  input  index_t           index,
  input  index_t           next_index,
  output block_t           data_out,
  output block_t           data_out_next
);

  index_t wr_index;

  // refill goes to the addressed block or to the one after it
  assign wr_index = fill.index_sel ? next_index : index;

  for (genvar b = 0; b < ICACHE_BYTES; b++) begin : g_byte
    logic [7:0] ram [ICACHE_DEPTH];
    logic [7:0] rd_byte;
    logic [7:0] rd_byte_next;

    always_ff @(negedge clk) begin
      if (fill.wren) begin
        ram[wr_index] <= fill.data[8*b +: 8];
      end
    end

    // two read ports, addressed and following block
    always_ff @(negedge clk) begin
      rd_byte      <= ram[index];
      rd_byte_next <= ram[next_index];
    end

    assign data_out[8*b +: 8]      = rd_byte;
    assign data_out_next[8*b +: 8] = rd_byte_next;
  end

endmodule

//--- icache/icache_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache controller, lookup and block refill sequencing
// requests are ignored while fetch_busy is high, including the result cycle
// fence_i only takes effect in idle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       fetch_req,
  input  addr_t                      fetch_addr,
  input  logic                       fence_i,
  output logic                       fetch_busy,
  output logic                       instr_valid,
  output logic                       mem_req,
  output addr_t                      mem_addr,
  input  logic                       mem_valid,
  input  block_t                     mem_data,
  input  logic                       hit,
  input  logic                       next_hit,
  output index_t                     index,
  output index_t                     next_index,
  output tag_t                       tag,
  output tag_t                       next_tag,
  output logic [ICACHE_OFFSET_W-1:0] offset,
  output logic                       flush,
  icache_fill_if.mp_ctrl             fill
);

  typedef enum logic [1:0] {
    st_idle,
    st_lookup,
    st_refill_wait,
    st_refill_write
  } state_t;

  state_t                                   state;
  addr_t                                    addr_q;
  block_t                                   fill_data;
  logic                                     sel_next;
  logic                                     take_req;
  logic                                     need_next;
  logic                                     all_hit;
  logic [ICACHE_ADDR_W-ICACHE_OFFSET_W-1:0] next_block_num;

  // no new request in the result cycle, busy still covers it
  assign take_req = (state == st_idle) && fetch_req && !instr_valid;

  assign tag    = addr_q[ICACHE_ADDR_W-1:ICACHE_TAG_LSB];
  assign index  = addr_q[ICACHE_TAG_LSB-1:ICACHE_INDEX_LSB];
  assign offset = addr_q[ICACHE_OFFSET_W-1:0];

  // following block, the carry out of the index runs into the tag
  assign next_block_num         = addr_q[ICACHE_ADDR_W-1:ICACHE_OFFSET_W] + 1'b1;
  assign {next_tag, next_index} = next_block_num;

  assign need_next = (offset == ICACHE_LAST_HALF);
  assign all_hit   = hit && (!need_next || next_hit);

  assign flush      = fence_i && (state == st_idle);
  assign fetch_busy = (state != st_idle) || instr_valid;

  assign mem_addr = sel_next ? {next_tag, next_index, {ICACHE_OFFSET_W{1'b0}}}
                             : {tag, index, {ICACHE_OFFSET_W{1'b0}}};

  assign fill.wren      = (state == st_refill_write);
  assign fill.index_sel = sel_next;
  assign fill.data      = fill_data;
  assign fill.tag       = sel_next ? next_tag : tag;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= st_idle;
      instr_valid <= 1'b0;
      mem_req     <= 1'b0;
      sel_next    <= 1'b0;
    end else begin
      instr_valid <= 1'b0;
      mem_req     <= 1'b0;
      case (state)
        st_idle: begin
          if (take_req) begin
            state <= st_lookup;
          end
        end
        st_lookup: begin
          if (all_hit) begin
            instr_valid <= 1'b1;
            state       <= st_idle;
          end else begin
            // addressed block first, following block once that one hits
            mem_req  <= 1'b1;
            sel_next <= hit;
            state    <= st_refill_wait;
          end
        end
        st_refill_wait: begin
          if (mem_valid) begin
            state <= st_refill_write;
          end
        end
        st_refill_write: begin
          state <= st_lookup;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_req) begin
      addr_q <= fetch_addr;
    end
    if ((state == st_refill_wait) && mem_valid) begin
      fill_data <= mem_data;
    end
  end

endmodule

//--- common/icache_fill_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// refill write from the cache controller into the data and tag arrays
// wren is a one-cycle pulse, the arrays write at the falling edge
// index_sel low writes the addressed index, high the following index
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface icache_fill_if import icache_pkg::*; ();

  logic   wren;
  logic   index_sel;
  block_t data;
  tag_t   tag;

  modport mp_ctrl (
    output wren,
    output index_sel,
    output data,
    output tag
  );

  modport mp_array (
    input wren,
    input index_sel,
    input data,
    input tag
  );

endinterface

//--- common/icache_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// geometry of the direct-mapped instruction cache with 16-byte blocks
// byte address splits into tag, index and byte offset from msb to lsb
// fetch addresses are halfword aligned so offset bit 0 is always zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package icache_pkg;

  localparam int ICACHE_ADDR_W   = 32;
  localparam int ICACHE_INDEX_W  = 6;
  localparam int ICACHE_OFFSET_W = 4;
  localparam int ICACHE_TAG_W    = ICACHE_ADDR_W - ICACHE_INDEX_W - ICACHE_OFFSET_W;
  localparam int ICACHE_DEPTH    = 1 << ICACHE_INDEX_W;
  localparam int ICACHE_BYTES    = 1 << ICACHE_OFFSET_W;
  localparam int ICACHE_BLOCK_W  = 8 * ICACHE_BYTES;
  localparam int ICACHE_INSTR_W  = 32;

  // lsb positions of the address fields
  localparam int ICACHE_INDEX_LSB = ICACHE_OFFSET_W;
  localparam int ICACHE_TAG_LSB   = ICACHE_INDEX_LSB + ICACHE_INDEX_W;

  // last halfword of a block, a 32-bit instruction here spills into the next block
  localparam logic [ICACHE_OFFSET_W-1:0] ICACHE_LAST_HALF = ICACHE_OFFSET_W'(ICACHE_BYTES - 2);

  typedef logic [ICACHE_ADDR_W-1:0]  addr_t;
  typedef logic [ICACHE_INDEX_W-1:0] index_t;
  typedef logic [ICACHE_TAG_W-1:0]   tag_t;
  // byte 0 sits in bits 7:0
  typedef logic [ICACHE_BLOCK_W-1:0] block_t;
  typedef logic [ICACHE_INSTR_W-1:0] instr_t;

endpackage
